/* bench/tb_sbit_out.sv */
/*
 * S-bit output block testbench
 * LFSR flag stimulus, Wishbone driver and a reference model of the line outputs
 */

`timescale 1ns/1ns

`include "sbit_out_macros.svh"

module tb_sbit_out
  import sbit_out_pkg::*;
;

  localparam logic [15:0] LFSR_SEED   = 16'd44;
  localparam int          ACK_TIMEOUT = 20;

  logic                   clock;
  logic                   reset;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  logic [`SBIT_ADR_W-1:0] wb_adr_i;
  wb_data_t               wb_dat_i;
  wb_data_t               wb_dat_o;
  logic                   wb_ack_o;
  vfat_map_t              active_vfats_i;
  ext_sbits_t             ext_sbits_o;

  logic [15:0]     lfsr_state;
  line_cfg_array_t cfg_mirror;
  int              mismatch_count;
  int              other_count;

  sbit_out_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .active_vfats_i (active_vfats_i),
    .ext_sbits_o    (ext_sbits_o)
  );

  // 4 ns clock
  always #2 clock = ~clock;

  // --------------------------------------------------------------------------
  // Random numbers and reference model
  // --------------------------------------------------------------------------

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Rows hold chips j, j+8, j+16
  function automatic eta_map_t model_eta(input vfat_map_t f);
    eta_map_t e;
    e = '0;
    for (int c = 0; c < `SBIT_NUM_VFATS; c++) begin
      if (f[c]) e[c % `SBIT_NUM_ETA] = 1'b1;
    end
    return e;
  endfunction

  // Four neighbouring chips per sector
  function automatic sector_map_t model_sector(input vfat_map_t f);
    sector_map_t s;
    s = '0;
    for (int c = 0; c < `SBIT_NUM_VFATS; c++) begin
      if (f[c]) s[c / 4] = 1'b1;
    end
    return s;
  endfunction

  function automatic ext_sbits_t model_sbits(input vfat_map_t f);
    ext_sbits_t  o;
    eta_map_t    e;
    sector_map_t s;
    int          sel;
    o = '0;
    e = model_eta(f);
    s = model_sector(f);
    for (int l = 0; l < `SBIT_NUM_LINES; l++) begin
      sel = cfg_mirror[l].sel;
      if (cfg_mirror[l].mode == MODE_VFAT && sel < 24) o[l] = f[sel];
      if (cfg_mirror[l].mode == MODE_ETA && sel < 8) o[l] = e[sel];
      if (cfg_mirror[l].mode == MODE_SECTOR && sel < 6) o[l] = s[sel];
    end
    return o;
  endfunction

  // Readback layout with select in 4:0 and mode in 9:8
  function automatic wb_data_t cfg_word(input line_cfg_t c);
    wb_data_t w;
    w = '0;
    w[4:0] = c.sel;
    w[9:8] = c.mode;
    return w;
  endfunction

  // --------------------------------------------------------------------------
  // Checks and bus driver
  // --------------------------------------------------------------------------

  task automatic check_sbits(input string name, input ext_sbits_t exp, input ext_sbits_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Inputs change and outputs are read 1 ns after the edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic bus_access(input logic we, input logic [3:0] adr, input wb_data_t wdata,
                            output wb_data_t rdata, output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    rdata  = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    while (!ok && waited < ACK_TIMEOUT) begin
      next_cycle();
      waited++;
      if (wb_ack_o === 1'b1) begin
        ok    = 1'b1;
        rdata = wb_dat_o;
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!ok) begin
      other_count++;
      $display("Timeout: no Wishbone ack within %0d cycles at address %0d", ACK_TIMEOUT, adr);
    end else begin
      if (waited != 1) begin
        other_count++;
        $display("Wishbone ack came %0d cycles after the request at address %0d", waited, adr);
      end
      next_cycle();
      if (wb_ack_o !== 1'b0) begin
        other_count++;
        $display("Wishbone ack stayed high for more than one cycle at address %0d", adr);
      end
    end
  endtask

  // Mirror follows only acknowledged line writes
  task automatic bus_write(input logic [3:0] adr, input wb_data_t data);
    wb_data_t unused;
    logic     ok;
    bus_access(1'b1, adr, data, unused, ok);
    if (ok && adr < 4'd8) begin
      cfg_mirror[adr[2:0]] = '{mode: sbit_mode_t'(data[9:8]), sel: data[4:0]};
    end
  endtask

  task automatic bus_read(input logic [3:0] adr, output wb_data_t data);
    logic ok;
    bus_access(1'b0, adr, '0, data, ok);
  endtask

  task automatic set_line(input int line, input sbit_mode_t mode, input logic [4:0] sel);
    bus_write(line[3:0], cfg_word('{mode: mode, sel: sel}));
  endtask

  // Random flags each cycle with the output compared against flags from two cycles back
  task automatic run_stream(input string name, input int cycles);
    vfat_map_t hist1;
    vfat_map_t hist2;
    vfat_map_t flags;
    hist1 = active_vfats_i;
    hist2 = active_vfats_i;
    for (int i = 0; i < cycles + 3; i++) begin
      next_cycle();
      // First three cycles let the new configuration settle
      if (i >= 3) check_sbits($sformatf("%s cycle %0d", name, i - 3), model_sbits(hist2),
                              ext_sbits_o);
      flags = vfat_map_t'(take_bits(`SBIT_NUM_VFATS));
      active_vfats_i = flags;
      hist2 = hist1;
      hist1 = flags;
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    wb_data_t   rd;
    logic [3:0] adr;
    vfat_map_t  held;
    clock          = 1'b0;
    reset          = 1'b1;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    active_vfats_i = '0;
    lfsr_state     = LFSR_SEED;
    mismatch_count = 0;
    other_count    = 0;
    for (int l = 0; l < `SBIT_NUM_LINES; l++) cfg_mirror[l] = '{mode: MODE_OFF, sel: '0};
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // Reset state
    next_cycle();
    check_sbits("reset outputs", '0, ext_sbits_o);
    if (wb_ack_o !== 1'b0) begin
      other_count++;
      $display("Wishbone ack is not low after reset");
    end
    for (int l = 0; l < `SBIT_NUM_LINES; l++) begin
      bus_read(l[3:0], rd);
      check_word($sformatf("reset line %0d", l), 32'h300, rd);
    end

    // Random line writes with readback
    for (int n = 0; n < 16; n++) begin
      adr = 4'(take_bits(3));
      bus_write(adr, take_bits(32));
      bus_read(adr, rd);
      check_word($sformatf("line %0d readback", adr), cfg_word(cfg_mirror[adr[2:0]]), rd);
    end
    // Status and unused addresses ignore writes
    for (int n = 0; n < 8; n++) begin
      adr = {1'b1, 3'(take_bits(3))};
      bus_write(adr, take_bits(32));
    end
    for (int l = 0; l < `SBIT_NUM_LINES; l++) begin
      bus_read(l[3:0], rd);
      check_word($sformatf("line %0d unchanged", l), cfg_word(cfg_mirror[l]), rd);
    end
    for (int a = 9; a < 16; a++) begin
      bus_read(a[3:0], rd);
      check_word($sformatf("unused address %0d", a), '0, rd);
    end

    // VFAT mode
    for (int l = 0; l < `SBIT_NUM_LINES; l++) set_line(l, MODE_VFAT, 5'(take_bits(5) % 24));
    run_stream("vfat mode", 200);

    // Eta and sector mix with selects over the whole field
    for (int l = 0; l < `SBIT_NUM_LINES; l++) begin
      set_line(l, take_bits(1) ? MODE_SECTOR : MODE_ETA, 5'(take_bits(5)));
    end
    run_stream("eta sector mode", 200);

    // Line 0 always off and the others by chance
    set_line(0, MODE_OFF, 5'(take_bits(5)));
    for (int l = 1; l < `SBIT_NUM_LINES; l++) begin
      if (take_bits(1)) set_line(l, MODE_OFF, 5'(take_bits(5)));
    end
    run_stream("off mode", 100);

    // Steady flags then status readback
    held = vfat_map_t'(take_bits(`SBIT_NUM_VFATS));
    active_vfats_i = held;
    repeat (3) next_cycle();
    bus_read(4'd8, rd);
    check_word("status", {18'b0, model_sector(held), model_eta(held)}, rd);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* common/sbit_out_macros.svh */
/*
 * S-bit output block geometry and Wishbone bus widths
 */

`ifndef SBIT_OUT_MACROS_SVH
`define SBIT_OUT_MACROS_SVH

// ---------------------------------------------------------------------------
// Chamber geometry
// ---------------------------------------------------------------------------

// VFAT readout chips, one activity flag each
`define SBIT_NUM_VFATS   24
// Eta partitions, three VFATs per row
`define SBIT_NUM_ETA     8
// Chamber sectors, four VFATs per sector
`define SBIT_NUM_SECTORS 6
// External HDMI trigger lines
`define SBIT_NUM_LINES   8
// Source select per line, wide enough for any VFAT index
`define SBIT_SEL_W       5

// ---------------------------------------------------------------------------
// Wishbone slave
// ---------------------------------------------------------------------------

`define SBIT_ADR_W       4
`define SBIT_DAT_W       32

`endif

/* common/sbit_out_pkg.sv */
/*
 * S-bit output types
 * Line source modes, register map and the flag/map vectors
 */

`include "sbit_out_macros.svh"

package sbit_out_pkg;

  // Source of one external line, codes fixed by the board convention
  typedef enum logic [1:0] {
    MODE_VFAT   = 2'd0,
    MODE_ETA    = 2'd1,
    MODE_SECTOR = 2'd2,
    MODE_OFF    = 2'd3
  } sbit_mode_t;

  // Register word addresses
  typedef enum logic [`SBIT_ADR_W-1:0] {
    REG_LINE0  = 'd0,
    REG_LINE1  = 'd1,
    REG_LINE2  = 'd2,
    REG_LINE3  = 'd3,
    REG_LINE4  = 'd4,
    REG_LINE5  = 'd5,
    REG_LINE6  = 'd6,
    REG_LINE7  = 'd7,
    REG_STATUS = 'd8   // read only
  } sbit_reg_adr_t;

  typedef logic [`SBIT_NUM_VFATS-1:0]   vfat_map_t;
  typedef logic [`SBIT_NUM_ETA-1:0]     eta_map_t;
  typedef logic [`SBIT_NUM_SECTORS-1:0] sector_map_t;
  typedef logic [`SBIT_NUM_LINES-1:0]   ext_sbits_t;
  typedef logic [`SBIT_DAT_W-1:0]       wb_data_t;

  // Per-line setting
  typedef struct packed {
    sbit_mode_t                mode;
    logic [`SBIT_SEL_W-1:0]    sel;
  } line_cfg_t;

  typedef line_cfg_t [`SBIT_NUM_LINES-1:0] line_cfg_array_t;

endpackage

/* filelist.f */
+incdir+common
common/sbit_out_pkg.sv
sbit_out/sbit_cfg_regs.sv
sbit_out/sbit_region_map.sv
sbit_out/sbit_out_mux.sv
hdl/sbit_out_top.sv
bench/tb_sbit_out.sv

/* hdl/sbit_out_top.sv */
/*
 * S-bit external output block
 * Register bank, region mapper and output mux for the HDMI trigger lines
 */

`timescale 1ns/1ns

`include "sbit_out_macros.svh"

module sbit_out_top
  import sbit_out_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,

  // Wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`SBIT_ADR_W-1:0] wb_adr_i,
  input  wb_data_t               wb_dat_i,
  output wb_data_t               wb_dat_o,
  output logic                   wb_ack_o,

  // VFAT activity flags in, trigger lines out
  input  vfat_map_t              active_vfats_i,
  output ext_sbits_t             ext_sbits_o
);

  line_cfg_array_t line_cfg;
  vfat_map_t       vfat_reg;
  eta_map_t        eta_reg;
  sector_map_t     sector_reg;

  // Decode: per-line settings and status readback
  sbit_cfg_regs i_cfg_regs (
    .clock        (clock),
    .reset        (reset),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .eta_map_i    (eta_reg),
    .sector_map_i (sector_reg),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .line_cfg_o   (line_cfg)
  );

  // Execute: first pipeline stage, flags and region maps
  sbit_region_map i_region_map (
    .clock          (clock),
    .reset          (reset),
    .active_vfats_i (active_vfats_i),
    .vfat_o         (vfat_reg),
    .eta_o          (eta_reg),
    .sector_o       (sector_reg)
  );

  // Result: second pipeline stage, per-line selection
  sbit_out_mux i_out_mux (
    .clock       (clock),
    .reset       (reset),
    .line_cfg_i  (line_cfg),
    .vfat_i      (vfat_reg),
    .eta_i       (eta_reg),
    .sector_i    (sector_reg),
    .ext_sbits_o (ext_sbits_o)
  );

endmodule

/* sbit_out/sbit_cfg_regs.sv */
/*
 * S-bit configuration registers
 * Wishbone classic slave with eight line settings and a live status word
 */

`timescale 1ns/1ns

`include "sbit_out_macros.svh"

module sbit_cfg_regs
  import sbit_out_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`SBIT_ADR_W-1:0] wb_adr_i,
  input  wb_data_t               wb_dat_i,
  input  eta_map_t               eta_map_i,
  input  sector_map_t            sector_map_i,
  output wb_data_t               wb_dat_o,
  output logic                   wb_ack_o,
  output line_cfg_array_t        line_cfg_o
);

  logic            ack_q;
  logic            wb_access;
  logic            is_line_adr;
  logic [2:0]      line_idx;
  sbit_reg_adr_t   reg_adr;
  wb_data_t        rd_data;
  line_cfg_array_t line_cfg_q;

  // ---------------------------------------------------------------------------
  // Address decode
  // ---------------------------------------------------------------------------

  // New access seen while no ack is pending
  assign wb_access = wb_cyc_i & wb_stb_i & ~ack_q;
  assign reg_adr   = sbit_reg_adr_t'(wb_adr_i);
  assign line_idx  = wb_adr_i[2:0];

  always_comb begin
    is_line_adr = 1'b0;
    rd_data     = '0;
    case (reg_adr)
      REG_LINE0, REG_LINE1, REG_LINE2, REG_LINE3,
      REG_LINE4, REG_LINE5, REG_LINE6, REG_LINE7: begin
        is_line_adr = 1'b1;
        // Select in the low field, mode at bits 9:8
        rd_data[`SBIT_SEL_W-1:0] = line_cfg_q[line_idx].sel;
        rd_data[9:8]             = line_cfg_q[line_idx].mode;
      end
      REG_STATUS: begin
        rd_data[`SBIT_NUM_ETA-1:0]                 = eta_map_i;
        rd_data[`SBIT_NUM_ETA +: `SBIT_NUM_SECTORS] = sector_map_i;
      end
      // Unused addresses read zero
      default: ;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Acknowledge and line settings
  // ---------------------------------------------------------------------------

  // One ack cycle per access, then back low
  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_access;
    end
  end

  // Line written at the same edge that raises ack
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `SBIT_NUM_LINES; i++) begin
        line_cfg_q[i] <= '{mode: MODE_OFF, sel: '0};
      end
    end else if (wb_access && wb_we_i && is_line_adr) begin
      line_cfg_q[line_idx].sel  <= wb_dat_i[`SBIT_SEL_W-1:0];
      line_cfg_q[line_idx].mode <= sbit_mode_t'(wb_dat_i[9:8]);
    end
  end

  assign wb_ack_o   = ack_q;
  // Read data held at zero outside the ack cycle
  assign wb_dat_o   = ack_q ? rd_data : '0;
  assign line_cfg_o = line_cfg_q;

  // ---------------------------------------------------------------------------
  // Bus protocol checks
  // ---------------------------------------------------------------------------

  // Ack only answers a request from the previous edge
  a_ack_follows_req: assert property (@(posedge clock) disable iff (reset)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

  // Single-cycle ack
  a_ack_single: assert property (@(posedge clock) disable iff (reset)
    wb_ack_o |=> !wb_ack_o);

endmodule

/* sbit_out/sbit_out_mux.sv */
/*
 * S-bit output multiplexer
 * Each external line picks one bit of its programmed source map
 */

`timescale 1ns/1ns

`include "sbit_out_macros.svh"

module sbit_out_mux
  import sbit_out_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  line_cfg_array_t line_cfg_i,
  input  vfat_map_t       vfat_i,
  input  eta_map_t        eta_i,
  input  sector_map_t     sector_i,
  output ext_sbits_t      ext_sbits_o
);

  ext_sbits_t sbits_next;

  // ---------------------------------------------------------------------------
  // Source selection
  // ---------------------------------------------------------------------------

  always_comb begin
    logic [`SBIT_SEL_W-1:0] sel;
    sel        = '0;
    sbits_next = '0;
    for (int i = 0; i < `SBIT_NUM_LINES; i++) begin
      sel = line_cfg_i[i].sel;
      case (line_cfg_i[i].mode)
        // Selects past the end of a map give zero
        MODE_VFAT: begin
          if (sel < `SBIT_NUM_VFATS) begin
            sbits_next[i] = vfat_i[sel];
          end
        end
        MODE_ETA: begin
          if (sel < `SBIT_NUM_ETA) begin
            sbits_next[i] = eta_i[sel[2:0]];
          end
        end
        MODE_SECTOR: begin
          if (sel < `SBIT_NUM_SECTORS) begin
            sbits_next[i] = sector_i[sel[2:0]];
          end
        end
        // Line switched off
        MODE_OFF: sbits_next[i] = 1'b0;
        default:  sbits_next[i] = 1'b0;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // Output register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      ext_sbits_o <= '0;
    end else begin
      ext_sbits_o <= sbits_next;
    end
  end

  // Line settings from the register bank are defined once out of reset
  for (genvar g = 0; g < `SBIT_NUM_LINES; g++) begin : g_mode_chk
    a_mode_known: assert property (@(posedge clock) disable iff (reset)
      !$isunknown(line_cfg_i[g].mode));
  end

endmodule

/* sbit_out/sbit_region_map.sv */
/*
 * S-bit region mapper
 * Registers the VFAT flags with their eta-row and sector OR reductions
 */

`timescale 1ns/1ns

`include "sbit_out_macros.svh"

module sbit_region_map
  import sbit_out_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  vfat_map_t   active_vfats_i,
  output vfat_map_t   vfat_o,
  output eta_map_t    eta_o,
  output sector_map_t sector_o
);

  // VFATs per sector
  localparam int VFATS_PER_SECTOR = `SBIT_NUM_VFATS / `SBIT_NUM_SECTORS;

  eta_map_t    eta_next;
  sector_map_t sector_next;

  always_comb begin
    // Row j collects chips j, j+8 and j+16
    for (int j = 0; j < `SBIT_NUM_ETA; j++) begin
      eta_next[j] = active_vfats_i[j] |
                    active_vfats_i[j + `SBIT_NUM_ETA] |
                    active_vfats_i[j + 2 * `SBIT_NUM_ETA];
    end
    // Sectors run top left to bottom right, four chips each
    for (int k = 0; k < `SBIT_NUM_SECTORS; k++) begin
      sector_next[k] = |active_vfats_i[k * VFATS_PER_SECTOR +: VFATS_PER_SECTOR];
    end
  end

  // Raw flags delayed with the reductions so all sources line up
  always_ff @(posedge clock) begin
    if (reset) begin
      vfat_o   <= '0;
      eta_o    <= '0;
      sector_o <= '0;
    end else begin
      vfat_o   <= active_vfats_i;
      eta_o    <= eta_next;
      sector_o <= sector_next;
    end
  end

  // Maps cleared together after reset
  a_maps_cleared: assert property (@(posedge clock)
    reset |=> (vfat_o == '0) && (eta_o == '0) && (sector_o == '0));

endmodule
